// File: rtl/pipePkg.sv
/* Pipeline control types for the memory stage: memory-function opcodes,
   execute-stage controls, the MEM-to-WB operation and the writeback result */

package pipePkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    // Register file address width
    localparam int REG_ADDR_W = 5;
    // Datapath word width
    localparam int DATA_W = 32;

    // --------------------------------------------------
    // Memory-function opcode
    // --------------------------------------------------
    // Stores treat the signed and unsigned forms alike
    // wordLeft/wordRight are the LWL/LWR and SWL/SWR forms
    typedef enum logic [2:0] {
        byteSigned   = 3'd0,
        byteUnsigned = 3'd1,
        halfSigned   = 3'd2,
        halfUnsigned = 3'd3,
        word         = 3'd4,
        wordLeft     = 3'd5,
        wordRight    = 3'd6
    } memFunc_e;

    // Level controls from the execute stage
    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic                  memRead;
        logic                  memWrite;
        memFunc_e              func;
        logic [REG_ADDR_W-1:0] rAddr;
    } memCtrl_t;

    // Operation carried from the store formatter into MEM/WB
    typedef struct packed {
        memCtrl_t          ctrl;
        logic [1:0]        byteOff;
        logic [DATA_W-1:0] aluData;
        logic [DATA_W-1:0] rtData;
    } memOp_t;

    // Result presented to the register file
    typedef struct packed {
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] rAddr;
        logic [DATA_W-1:0]     data;
    } wbResult_t;

endpackage

// File: rtl/memPkg.sv
/* Data memory geometry and the per-lane bank request */

package memPkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    // Byte address width seen by the data memory
    localparam int ADDR_W = 16;

    // One byte-wide bank per byte of the word
    localparam int NUM_LANES = 4;

    // Address bits above the byte offset select the word
    localparam int WORD_ADDR_W = ADDR_W - 2;

    // Words held in each bank
    localparam int DEPTH = 2 ** WORD_ADDR_W;

    // --------------------------------------------------
    // Lane request
    // --------------------------------------------------
    // One bank gets one of these each cycle
    // The read happens whatever we is; wdata only matters with we set
    typedef struct packed {
        logic                   we;
        logic [WORD_ADDR_W-1:0] wordAddr;
        logic [7:0]             wdata;
    } laneReq_t;

endpackage

// File: rtl/memBank.sv
/* One byte-wide data memory lane with synchronous write and registered read */

`timescale 1ns/10ps

module memBank import memPkg::*; (
    input  logic       clk,
    input  laneReq_t   req,
    output logic [7:0] rdata
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    // Contents are undefined until written
    logic [7:0] mem [DEPTH];

    // Write when enabled
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.wordAddr] <= req.wdata;
        end
    end

    // Read every edge, so rdata always trails the address by one cycle
    // Old contents are returned on a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[req.wordAddr];
    end

endmodule

// File: rtl/memStage.sv
/* Store formatter: spreads one operation over four byte-lane bank requests
   and forwards the operation toward MEM/WB */

`timescale 1ns/10ps

module memStage import pipePkg::*, memPkg::*; (
    input  memCtrl_t                      ctrl,
    input  logic     [DATA_W-1:0]         aluData,
    input  logic     [DATA_W-1:0]         rtData,
    output laneReq_t [NUM_LANES-1:0]      laneReq,
    output memOp_t                        memOp
);

    // --------------------------------------------------
    // Address split
    // --------------------------------------------------
    logic [ADDR_W-1:0]      byteAddr;
    logic [WORD_ADDR_W-1:0] wordAddr;
    logic [1:0]             byteOff;

    // Store data already moved into lane position
    logic [DATA_W-1:0]      wdataWord;
    // Lanes the store touches
    logic [NUM_LANES-1:0]   laneMask;

    // Shift amounts for the left/right word forms
    logic [4:0]             leftShift;
    logic [4:0]             rightShift;

    assign byteAddr = aluData[ADDR_W-1:0];
    assign wordAddr = byteAddr[ADDR_W-1:2];
    assign byteOff  = byteAddr[1:0];

    // SWL moves rt's top bytes down to lane 0
    assign leftShift  = {2'd3 - byteOff, 3'b000};
    // SWR moves rt's low bytes up to lane o
    assign rightShift = {byteOff, 3'b000};

    // --------------------------------------------------
    // Lane data and mask per function
    // --------------------------------------------------
    always_comb begin
        wdataWord = rtData;
        laneMask  = '0;
        case (ctrl.func)
            byteSigned, byteUnsigned: begin
                // Low byte copied to every lane, only lane o enabled
                wdataWord = {4{rtData[7:0]}};
                laneMask  = 4'b0001 << byteOff;
            end
            halfSigned, halfUnsigned: begin
                // Address bit 1 picks the upper or lower half; bit 0 ignored
                wdataWord = {2{rtData[15:0]}};
                laneMask  = byteOff[1] ? 4'b1100 : 4'b0011;
            end
            word: begin
                wdataWord = rtData;
                laneMask  = 4'b1111;
            end
            wordLeft: begin
                // Lanes 0..o get rt's top o+1 bytes
                wdataWord = rtData >> leftShift;
                laneMask  = ~(4'b1110 << byteOff);
            end
            wordRight: begin
                // Lanes o..3 get rt's low 4-o bytes
                wdataWord = rtData << rightShift;
                laneMask  = 4'b1111 << byteOff;
            end
            default: begin
                // Unused encoding writes nothing
                wdataWord = rtData;
                laneMask  = '0;
            end
        endcase
    end

    // --------------------------------------------------
    // Lane requests
    // --------------------------------------------------
    // Every lane reads the same word every cycle
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laneReq[i].we       = ctrl.memWrite & laneMask[i];
            laneReq[i].wordAddr = wordAddr;
            laneReq[i].wdata    = wdataWord[8*i +: 8];
        end
    end

    // Operation handed on to the load aligner
    always_comb begin
        memOp.ctrl    = ctrl;
        memOp.byteOff = byteOff;
        memOp.aluData = aluData;
        memOp.rtData  = rtData;
    end

endmodule

// File: rtl/loadAlign.sv
/* MEM/WB register with load alignment, sign/zero extension, LWL/LWR merge
   and writeback select */

`timescale 1ns/10ps

module loadAlign import pipePkg::*; (
    input  logic                         clk,
    input  logic                         rstN,
    input  memOp_t                       memOp,
    input  logic [DATA_W/8-1:0][7:0]     laneData,
    output wbResult_t                    wbOut
);

    // --------------------------------------------------
    // MEM/WB register
    // --------------------------------------------------
    // Captured at the same edge the banks register their reads
    memOp_t opQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opQ <= '0;
        end else begin
            opQ <= memOp;
        end
    end

    // --------------------------------------------------
    // Lane selection
    // --------------------------------------------------
    // Whole word as read, lane 0 is the lowest address
    logic [DATA_W-1:0] memWord;
    // Byte at offset o
    logic [7:0]        byteSel;
    // Half chosen by address bit 1
    logic [15:0]       halfSel;

    assign memWord = laneData;
    assign byteSel = laneData[opQ.byteOff];
    assign halfSel = opQ.byteOff[1] ? {laneData[3], laneData[2]}
                                    : {laneData[1], laneData[0]};

    // --------------------------------------------------
    // Left/right merge
    // --------------------------------------------------
    logic [4:0]        leftShift;
    logic [4:0]        rightShift;
    // Bits of rt that the memory bytes overwrite
    logic [DATA_W-1:0] leftMask;
    logic [DATA_W-1:0] rightMask;
    logic [DATA_W-1:0] leftData;
    logic [DATA_W-1:0] rightData;

    // LWL lifts bytes 0..o to the top of the word
    assign leftShift  = {2'd3 - opQ.byteOff, 3'b000};
    // LWR drops bytes o..3 to the bottom
    assign rightShift = {opQ.byteOff, 3'b000};

    assign leftMask  = {DATA_W{1'b1}} << leftShift;
    assign rightMask = {DATA_W{1'b1}} >> rightShift;

    // rt keeps its lower 3-o bytes
    assign leftData  = (memWord << leftShift) | (opQ.rtData & ~leftMask);
    // rt keeps its upper o bytes
    assign rightData = (memWord >> rightShift) | (opQ.rtData & ~rightMask);

    // --------------------------------------------------
    // Load value
    // --------------------------------------------------
    logic [DATA_W-1:0] loadData;

    always_comb begin
        case (opQ.ctrl.func)
            byteSigned: begin
                loadData = {{24{byteSel[7]}}, byteSel};
            end
            byteUnsigned: begin
                loadData = {24'd0, byteSel};
            end
            halfSigned: begin
                loadData = {{16{halfSel[15]}}, halfSel};
            end
            halfUnsigned: begin
                loadData = {16'd0, halfSel};
            end
            word: begin
                loadData = memWord;
            end
            wordLeft: begin
                loadData = leftData;
            end
            wordRight: begin
                loadData = rightData;
            end
            default: begin
                // Unused encoding behaves as a plain word load
                loadData = memWord;
            end
        endcase
    end

    // --------------------------------------------------
    // Writeback
    // --------------------------------------------------
    // memToReg picks memory over the ALU result
    always_comb begin
        wbOut.regWrite = opQ.ctrl.regWrite;
        wbOut.rAddr    = opQ.ctrl.rAddr;
        wbOut.data     = opQ.ctrl.memToReg ? loadData : opQ.aluData;
    end

endmodule

// File: rtl/memSubsystem.sv
/* Memory stage top: store formatter, four byte-lane banks and load aligner */

`timescale 1ns/10ps

module memSubsystem import pipePkg::*, memPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  memCtrl_t          ctrlIn,
    input  logic [DATA_W-1:0] aluData,
    input  logic [DATA_W-1:0] rtData,
    output wbResult_t         wbOut
);

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    // Per-lane bank requests from the formatter
    laneReq_t [NUM_LANES-1:0]        laneReq;
    // Registered bank outputs, lane 0 lowest
    logic     [NUM_LANES-1:0][7:0]   laneData;
    // Operation on its way to MEM/WB
    memOp_t                          memOp;

    // Store formatting and address split
    memStage memStage_i (
        .ctrl    (ctrlIn),
        .aluData (aluData),
        .rtData  (rtData),
        .laneReq (laneReq),
        .memOp   (memOp)
    );

    // --------------------------------------------------
    // Byte-lane banks
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        memBank memBank_i (
            .clk   (clk),
            .req   (laneReq[i]),
            .rdata (laneData[i])
        );
    end

    // MEM/WB register and load formatting
    loadAlign loadAlign_i (
        .clk      (clk),
        .rstN     (rstN),
        .memOp    (memOp),
        .laneData (laneData),
        .wbOut    (wbOut)
    );

endmodule

// File: tests/memSubsystem_properties.sv
/* Concurrent checks on reset, lane write enables and writeback timing */

`timescale 1ns/10ps

module memSubsystem_properties import pipePkg::*, memPkg::*; (
    input logic                     clk,
    input logic                     rstN,
    input memCtrl_t                 ctrlIn,
    input laneReq_t [NUM_LANES-1:0] laneReq,
    input wbResult_t                wbOut
);

    // Write enables gathered from the lane requests
    logic [NUM_LANES-1:0] laneWe;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laneWe[i] = laneReq[i].we;
        end
    end

    // --------------------------------------------------
    // Properties
    // --------------------------------------------------
    // MEM/WB is cleared while reset is held
    resetClearsWb: assert property (@(posedge clk) !rstN |-> !wbOut.regWrite)
        else $error("wbOut.regWrite high while rstN is low");

    // Only a store may enable a bank write
    weNeedsStore: assert property (@(posedge clk) disable iff (!rstN)
        !ctrlIn.memWrite |-> laneWe == '0)
        else $error("Lane write enable without memWrite");

    // Fixed one-cycle latency through MEM/WB
    wbOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> wbOut.regWrite == $past(ctrlIn.regWrite))
        else $error("wbOut.regWrite does not follow ctrlIn.regWrite by one cycle");

endmodule

bind memSubsystem memSubsystem_properties memSubsystem_properties_i (
    .clk     (clk),
    .rstN    (rstN),
    .ctrlIn  (ctrlIn),
    .laneReq (laneReq),
    .wbOut   (wbOut)
);

// File: tests/memSubsystem_tb.sv
/* Memory stage testbench with clock, reset, directed and random operations,
   byte-level reference memory, compare process and watchdog */

`timescale 1ns/10ps

module memSubsystem_tb import pipePkg::*, memPkg::*; ();

    // --------------------------------------------------
    // Run length
    // --------------------------------------------------
    localparam int INIT_OPS     = 16;
    // 1 + 3 + 20 + 20 + 24 + 9 over behaviors 1 to 5
    localparam int DIRECTED_OPS = 77;
    localparam int RANDOM_OPS   = 500;
    localparam int OP_COUNT     = INIT_OPS + DIRECTED_OPS + RANDOM_OPS;
    // One operation per 10 ns cycle plus slack for reset and drain
    localparam int WATCHDOG_NS  = (OP_COUNT + 20) * 10;

    logic              clk = 1'b0;
    logic              rstN;
    memCtrl_t          ctrlIn;
    logic [DATA_W-1:0] aluData;
    logic [DATA_W-1:0] rtData;
    wbResult_t         wbOut;

    // Byte-wide model of the data memory that holds X until written
    logic [7:0]        refMem [2**ADDR_W];
    // Expected writeback values in issue order
    wbResult_t         expQ [$];
    int                issuedCount = 0;
    int                checkCount  = 0;
    int                errorCount  = 0;
    logic [31:0]       rngState    = 32'd61197;

    memSubsystem memSubsystem_i (
        .clk     (clk),
        .rstN    (rstN),
        .ctrlIn  (ctrlIn),
        .aluData (aluData),
        .rtData  (rtData),
        .wbOut   (wbOut)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Fill byte for the low window that depends on every address bit
    function automatic logic [7:0] fillByte(input int a);
        return 8'((a * 37 + 11) ^ (a >> 2));
    endfunction

    function automatic memCtrl_t makeCtrl(input memFunc_e f, input logic wr,
                                          input logic toReg, input logic regWr,
                                          input logic [4:0] rd);
        memCtrl_t c;
        c.regWrite = regWr;
        c.memToReg = toReg;
        c.memRead  = toReg;
        c.memWrite = wr;
        c.func     = f;
        c.rAddr    = rd;
        return c;
    endfunction

    // Reference model where the load reads the old bytes before the store updates them
    function automatic wbResult_t modelOp(input memCtrl_t c, input logic [31:0] alu,
                                          input logic [31:0] rt);
        wbResult_t   r;
        logic [15:0] base;
        logic [7:0]  m [4];
        logic [15:0] half;
        logic [31:0] ld;
        int          o;
        int          h;
        int          j;
        base = {alu[15:2], 2'b00};
        o    = alu[1:0];
        // Address bit 1 picks the half and bit 0 is ignored
        h    = alu[1] ? 2 : 0;
        for (j = 0; j < 4; j++) begin
            m[j] = refMem[base + j];
        end
        half = {m[h + 1], m[h]};
        ld   = rt;
        case (c.func)
            byteSigned:   ld = {{24{m[o][7]}}, m[o]};
            byteUnsigned: ld = {24'd0, m[o]};
            halfSigned:   ld = {{16{half[15]}}, half};
            halfUnsigned: ld = {16'd0, half};
            wordLeft: begin
                // Bytes 0..o go to the top and rt keeps its lower 3-o bytes
                for (j = 3 - o; j < 4; j++) begin
                    ld[8*j +: 8] = m[j - (3 - o)];
                end
            end
            wordRight: begin
                // Bytes o..3 go to the bottom and rt keeps its upper o bytes
                for (j = 0; j <= 3 - o; j++) begin
                    ld[8*j +: 8] = m[j + o];
                end
            end
            default: ld = {m[3], m[2], m[1], m[0]};
        endcase
        if (c.memWrite) begin
            case (c.func)
                byteSigned, byteUnsigned: refMem[base + o] = rt[7:0];
                halfSigned, halfUnsigned: begin
                    refMem[base + h]     = rt[7:0];
                    refMem[base + h + 1] = rt[15:8];
                end
                word: begin
                    for (j = 0; j < 4; j++) begin
                        refMem[base + j] = rt[8*j +: 8];
                    end
                end
                wordLeft: begin
                    // Lanes 0..o take rt's top o+1 bytes
                    for (j = 0; j <= o; j++) begin
                        refMem[base + j] = rt[8*(j + 3 - o) +: 8];
                    end
                end
                wordRight: begin
                    // Lanes o..3 take rt's low 4-o bytes
                    for (j = o; j < 4; j++) begin
                        refMem[base + j] = rt[8*(j - o) +: 8];
                    end
                end
                default: ;
            endcase
        end
        r.regWrite = c.regWrite;
        r.rAddr    = c.rAddr;
        r.data     = c.memToReg ? ld : alu;
        return r;
    endfunction

    task automatic stopOnError(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkResult(input wbResult_t got, input wbResult_t exp);
        if (got.data !== exp.data) begin
            stopOnError($sformatf("FAIL at %0t: writeback data %h, expected %h",
                                  $time, got.data, exp.data));
        end
    endtask

    task automatic checkCtrl(input memCtrl_t got, input memCtrl_t exp);
        if (got.regWrite !== exp.regWrite || got.rAddr !== exp.rAddr) begin
            stopOnError($sformatf("FAIL at %0t: regWrite/rAddr %b/%0d, expected %b/%0d",
                                  $time, got.regWrite, got.rAddr, exp.regWrite, exp.rAddr));
        end
    endtask

    // One operation per call presented for the next edge
    task automatic issue(input memCtrl_t c, input logic [31:0] alu, input logic [31:0] rt);
        @(posedge clk);
        ctrlIn  <= c;
        aluData <= alu;
        rtData  <= rt;
        expQ.push_back(modelOp(c, alu, rt));
        issuedCount++;
    endtask

    task automatic storeOp(input memFunc_e f, input logic [31:0] addr, input logic [31:0] rt);
        issue(makeCtrl(f, 1'b1, 1'b0, 1'b0, 5'd0), addr, rt);
    endtask

    task automatic loadOp(input memFunc_e f, input logic [31:0] addr, input logic [31:0] rt);
        issue(makeCtrl(f, 1'b0, 1'b1, 1'b1, addr[4:0] + 5'd3), addr, rt);
    endtask

    // --------------------------------------------------
    // Compare process
    // --------------------------------------------------
    // An entry pushed at edge k is taken at the following falling edge
    // and checked one cycle later once the MEM/WB register holds it
    initial begin
        wbResult_t pending;
        bit        havePending;
        memCtrl_t  gotCtrl;
        memCtrl_t  expCtrl;
        havePending = 1'b0;
        forever begin
            @(negedge clk);
            if (havePending) begin
                gotCtrl          = '0;
                gotCtrl.regWrite = wbOut.regWrite;
                gotCtrl.rAddr    = wbOut.rAddr;
                expCtrl          = '0;
                expCtrl.regWrite = pending.regWrite;
                expCtrl.rAddr    = pending.rAddr;
                checkCtrl(gotCtrl, expCtrl);
                checkResult(wbOut, pending);
                checkCount++;
            end
            havePending = (expQ.size() > 0);
            if (havePending) begin
                pending = expQ.pop_front();
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        stopOnError("Timeout: the run did not finish before the watchdog expired");
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int          o;
        int          n;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        memCtrl_t    rstCtrl;
        rstN    = 1'b0;
        ctrlIn  = '0;
        aluData = '0;
        rtData  = '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // 1. Cleared MEM/WB and then an ALU result passing through
        @(negedge clk);
        rstCtrl          = '0;
        rstCtrl.regWrite = wbOut.regWrite;
        rstCtrl.rAddr    = wbOut.rAddr;
        checkCtrl(rstCtrl, '0);
        checkResult(wbOut, '0);
        issue(makeCtrl(word, 1'b0, 1'b0, 1'b1, 5'd9), 32'hDEAD_BEEF, 32'h0);

        // Low 64-byte window used by the random phase
        for (n = 0; n < INIT_OPS; n++) begin
            storeOp(word, 4 * n, {fillByte(4 * n + 3), fillByte(4 * n + 2),
                                  fillByte(4 * n + 1), fillByte(4 * n)});
        end

        // 2. Store then load next cycle and a misaligned word load ignoring low bits
        storeOp(word, 32'h100, 32'h1234_5678);
        loadOp(word, 32'h100, 32'h0);
        loadOp(word, 32'h103, 32'h0);

        // 3. Byte and halfword at every offset
        for (o = 0; o < 4; o++) begin
            storeOp(word, 32'h200, 32'hA5A5_A5A5);
            storeOp(byteSigned, 32'h200 + o, o[0] ? 32'hFFFF_FF3B : 32'h0000_00C4);
            loadOp(byteSigned, 32'h200 + o, 32'hFFFF_FFFF);
            loadOp(byteUnsigned, 32'h200 + o, 32'hFFFF_FFFF);
            loadOp(word, 32'h200, 32'h0);
        end
        for (o = 0; o < 4; o++) begin
            storeOp(word, 32'h280, 32'h5A5A_5A5A);
            storeOp(halfUnsigned, 32'h280 + o, o[0] ? 32'hDEAD_7E12 : 32'hDEAD_81F3);
            loadOp(halfSigned, 32'h280 + o, 32'h0);
            loadOp(halfUnsigned, 32'h280 + o, 32'h0);
            loadOp(word, 32'h280, 32'h0);
        end

        // 4. SWL and SWR checked through word loads
        for (o = 0; o < 4; o++) begin
            storeOp(word, 32'h300, 32'h1122_3344);
            storeOp(wordLeft, 32'h300 + o, 32'hA1B2_C3D4);
            loadOp(word, 32'h300, 32'h0);
            storeOp(word, 32'h300, 32'h1122_3344);
            storeOp(wordRight, 32'h300 + o, 32'hA1B2_C3D4);
            loadOp(word, 32'h300, 32'h0);
        end

        // 5. LWL and LWR merge with rt
        storeOp(word, 32'h400, 32'h8899_AABB);
        for (o = 0; o < 4; o++) begin
            loadOp(wordLeft, 32'h400 + o, 32'h0123_4567);
            loadOp(wordRight, 32'h400 + o, 32'h0123_4567);
        end

        // 6. Random back-to-back operations with random ALU bits above the address
        for (n = 0; n < RANDOM_OPS; n++) begin
            r0 = nextRand();
            r1 = nextRand();
            r2 = nextRand();
            issue(makeCtrl(memFunc_e'(3'(r0 % 7)), r0[8], r0[9], r0[10], r0[15:11]),
                  {r1[31:16], 10'd0, r1[5:0]}, r2);
        end

        // Drain the pipeline before deciding
        wait (checkCount == issuedCount);
        @(negedge clk);
        if (errorCount == 0 && expQ.size() == 0 && issuedCount == OP_COUNT) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: memSubsystem.f
rtl/pipePkg.sv
rtl/memPkg.sv
rtl/memBank.sv
rtl/memStage.sv
rtl/loadAlign.sv
rtl/memSubsystem.sv
tests/memSubsystem_properties.sv
tests/memSubsystem_tb.sv
